//--- hw/tx_pkg.sv
package tx_pkg;

  // frame selection, also visible on the frame_type output
  typedef enum logic [1:0] {
    FRAME_NONE      = 2'd0,
    FRAME_TELEMETRY = 2'd1,
    FRAME_LIGHTDIAG = 2'd2,
    FRAME_STARDIAG  = 2'd3
  } frame_t;

  typedef logic [31:0] sram_word_t;
  typedef logic [15:0] link_word_t;

  // ----------------------------------------
  // sizes
  // ----------------------------------------
  localparam int ROW_W         = 11;
  localparam int ADDR_W        = 24;
  localparam int CNT_W         = 11;
  localparam int WORDS_PER_ROW = 8;
  localparam int LINK_PER_ROW  = 2 * WORDS_PER_ROW;
  localparam int FIFO_DEPTH    = 16;
  localparam int FIFO_PTR_W    = $clog2(FIFO_DEPTH);

  localparam logic [ROW_W-1:0] ROWS_TELEMETRY = 11'd2;
  localparam logic [ROW_W-1:0] ROWS_LIGHTDIAG = 11'd4;
  localparam logic [ROW_W-1:0] ROWS_STARDIAG  = 11'd3;

  localparam logic [ADDR_W-1:0] BASE_TELEMETRY = 24'h000000;
  localparam logic [ADDR_W-1:0] BASE_LIGHTDIAG = 24'h010000;
  localparam logic [ADDR_W-1:0] BASE_STARDIAG  = 24'h020000;

  // ----------------------------------------
  // link words and control flags
  // ----------------------------------------
  localparam link_word_t IDLE_WORD = 16'h50bc;
  localparam link_word_t SOF_WORD  = 16'hfbfb;
  localparam logic [1:0] CTRL_IDLE = 2'b01;
  localparam logic [1:0] CTRL_SOF  = 2'b11;
  localparam logic [1:0] CTRL_DATA = 2'b00;

  // rows per frame, zero for no frame
  function automatic logic [ROW_W-1:0] row_count(frame_t f);
    case (f)
      FRAME_TELEMETRY: return ROWS_TELEMETRY;
      FRAME_LIGHTDIAG: return ROWS_LIGHTDIAG;
      FRAME_STARDIAG:  return ROWS_STARDIAG;
      default:         return '0;
    endcase
  endfunction

  // sram start address of one row
  function automatic logic [ADDR_W-1:0] row_addr(frame_t f, logic [ROW_W-1:0] r);
    logic [ADDR_W-1:0] base;
    case (f)
      FRAME_LIGHTDIAG: base = BASE_LIGHTDIAG;
      FRAME_STARDIAG:  base = BASE_STARDIAG;
      default:         base = BASE_TELEMETRY;
    endcase
    return base + ADDR_W'(r) * ADDR_W'(WORDS_PER_ROW);
  endfunction

endpackage

//--- hw/tx_sequencer.sv
`timescale 1ns/1ps

module tx_sequencer (
  input  logic                     sys_clk,
  input  logic                     reset,
  input  logic                     timing_telemetry,
  input  logic                     timing_lightdiag,
  input  logic                     timing_stardiag,
  input  logic                     read_done,
  output logic                     start_read,
  output logic [tx_pkg::ROW_W-1:0] row,
  output tx_pkg::frame_t           frame_type,
  output logic                     transmit_done
);

  // bit 0 telemetry, bit 1 light diag, bit 2 star diag
  logic [2:0] sync1;
  logic [2:0] sync2;
  logic [2:0] sync_q;
  logic [2:0] rise;

  // ----------------------------------------
  // strobe synchronizers and edge detect
  // ----------------------------------------
  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      sync1  <= '0;
      sync2  <= '0;
      sync_q <= '0;
    end
    else
    begin
      sync1  <= {timing_stardiag, timing_lightdiag, timing_telemetry};
      sync2  <= sync1;
      sync_q <= sync2;
    end
  end

  assign rise = sync2 & ~sync_q;

  // ----------------------------------------
  // frame select and row stepping
  // ----------------------------------------
  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      start_read    <= 1'b0;
      transmit_done <= 1'b0;
      row           <= '0;
      frame_type    <= tx_pkg::FRAME_NONE;
    end
    else
    begin
      start_read    <= 1'b0;
      transmit_done <= 1'b0;
      if (frame_type == tx_pkg::FRAME_NONE)
      begin
        // telemetry wins over light diag, light diag over star
        if (rise[0])
          frame_type <= tx_pkg::FRAME_TELEMETRY;
        else if (rise[1])
          frame_type <= tx_pkg::FRAME_LIGHTDIAG;
        else if (rise[2])
          frame_type <= tx_pkg::FRAME_STARDIAG;
        if (rise != 3'b000)
        begin
          row        <= '0;
          start_read <= 1'b1;
        end
      end
      else if (transmit_done)
        frame_type <= tx_pkg::FRAME_NONE;
      else if (read_done)
      begin
        if (row == tx_pkg::row_count(frame_type) - 11'd1)
          transmit_done <= 1'b1;
        else
        begin
          row        <= row + 11'd1;
          start_read <= 1'b1;
        end
      end
    end
  end

endmodule

//--- hw/line_fifo.sv
`timescale 1ns/1ps

module line_fifo #(
  parameter type payload_t = tx_pkg::sram_word_t
) (
  input  logic     sys_clk,
  input  logic     reset,
  input  logic     wr_en,
  input  payload_t wdata,
  input  logic     rd_en,
  output payload_t dout,
  output logic     empty
);

  payload_t mem [tx_pkg::FIFO_DEPTH];

  logic [tx_pkg::FIFO_PTR_W-1:0] wr_ptr;
  logic [tx_pkg::FIFO_PTR_W-1:0] rd_ptr;
  logic [tx_pkg::FIFO_PTR_W:0]   count;
  logic                          full;
  logic                          do_wr;
  logic                          do_rd;

  assign full  = (count == tx_pkg::FIFO_DEPTH);
  assign empty = (count == '0);
  // writes into a full buffer are lost
  assign do_wr = wr_en && !full;
  assign do_rd = rd_en && !empty;

  // storage and registered read port
  always_ff @(posedge sys_clk)
  begin
    if (do_wr)
      mem[wr_ptr] <= wdata;
    if (do_rd)
      dout <= mem[rd_ptr];
  end

  // pointers wrap naturally, depth is a power of two
  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- hw/frame_builder.sv
`timescale 1ns/1ps

module frame_builder (
  input  logic                      sys_clk,
  input  logic                      reset,
  input  logic                      start_read,
  input  logic [tx_pkg::ROW_W-1:0]  row,
  input  tx_pkg::frame_t            frame_type,
  output logic                      read_done,
  output logic                      rd_req,
  output logic [tx_pkg::ADDR_W-1:0] sram_raddr,
  output logic                      rd_en,
  input  logic                      empty,
  input  tx_pkg::sram_word_t        fifo_data,
  output tx_pkg::link_word_t        tx_data,
  output logic [1:0]                tx_control,
  output logic [tx_pkg::CNT_W-1:0]  data_cnt
);

  // state names follow what the link or the sram port carries
  typedef enum logic [2:0] {ST_IDLE, ST_REQ, ST_SOF, ST_HDR, ST_PAYLOAD} state_t;

  state_t                                state;
  tx_pkg::frame_t                        frame_q;
  logic [tx_pkg::ROW_W-1:0]              row_q;
  logic [$clog2(tx_pkg::WORDS_PER_ROW):0] pop_cnt;
  logic [tx_pkg::CNT_W-1:0]              pay_cnt;
  logic                                  pop_q;
  logic                                  have_lo;
  tx_pkg::link_word_t                    lo_q;

  // ----------------------------------------
  // fifo pops
  // ----------------------------------------
  // at most one pop every other cycle, each word fills two link slots
  assign rd_en = (state == ST_HDR || state == ST_PAYLOAD) && !empty && !pop_q
                 && (pop_cnt < tx_pkg::WORDS_PER_ROW);

  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      pop_q   <= 1'b0;
      pop_cnt <= '0;
    end
    else
    begin
      pop_q <= rd_en;
      if (state == ST_IDLE)
        pop_cnt <= '0;
      else if (rd_en)
        pop_cnt <= pop_cnt + 1'b1;
    end
  end

  // low half waits one cycle behind the high half
  always_ff @(posedge sys_clk)
  begin
    if (pop_q)
      lo_q <= fifo_data[15:0];
  end

  // ----------------------------------------
  // row FSM and link output
  // ----------------------------------------
  always_ff @(posedge sys_clk)
  begin
    if (reset)
    begin
      state      <= ST_IDLE;
      rd_req     <= 1'b0;
      read_done  <= 1'b0;
      sram_raddr <= '0;
      frame_q    <= tx_pkg::FRAME_NONE;
      row_q      <= '0;
      pay_cnt    <= '0;
      have_lo    <= 1'b0;
      tx_data    <= tx_pkg::IDLE_WORD;
      tx_control <= tx_pkg::CTRL_IDLE;
      data_cnt   <= '0;
    end
    else
    begin
      // idle comma unless a state sends something
      rd_req     <= 1'b0;
      read_done  <= 1'b0;
      tx_data    <= tx_pkg::IDLE_WORD;
      tx_control <= tx_pkg::CTRL_IDLE;
      data_cnt   <= '0;
      case (state)
        ST_IDLE:
        begin
          if (start_read)
          begin
            rd_req     <= 1'b1;
            sram_raddr <= tx_pkg::row_addr(frame_type, row);
            frame_q    <= frame_type;
            row_q      <= row;
            pay_cnt    <= '0;
            have_lo    <= 1'b0;
            state      <= ST_REQ;
          end
        end
        ST_REQ:
        begin
          tx_data    <= tx_pkg::SOF_WORD;
          tx_control <= tx_pkg::CTRL_SOF;
          state      <= ST_SOF;
        end
        ST_SOF:
        begin
          tx_data    <= {frame_q, 3'b000, row_q};
          tx_control <= tx_pkg::CTRL_DATA;
          state      <= ST_HDR;
        end
        ST_HDR:
          state <= ST_PAYLOAD;
        ST_PAYLOAD:
        begin
          if (pay_cnt == tx_pkg::LINK_PER_ROW)
          begin
            read_done <= 1'b1;
            state     <= ST_IDLE;
          end
          else if (pop_q)
          begin
            tx_data    <= fifo_data[31:16];
            tx_control <= tx_pkg::CTRL_DATA;
            have_lo    <= 1'b1;
            pay_cnt    <= pay_cnt + 11'd1;
            data_cnt   <= pay_cnt + 11'd1;
          end
          else if (have_lo)
          begin
            tx_data    <= lo_q;
            tx_control <= tx_pkg::CTRL_DATA;
            have_lo    <= 1'b0;
            pay_cnt    <= pay_cnt + 11'd1;
            data_cnt   <= pay_cnt + 11'd1;
          end
          // otherwise fifo ran dry, stay here on idle commas
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

endmodule

//--- hw/data_tx.sv
`timescale 1ns/1ps

module data_tx (
  input  logic                      sys_clk,
  input  logic                      reset,
  input  logic                      timing_telemetry,
  input  logic                      timing_lightdiag,
  input  logic                      timing_stardiag,
  input  logic                      fifo_wr_en,
  input  tx_pkg::sram_word_t        fifo_wdata,
  output logic                      transmit_done,
  output tx_pkg::link_word_t        tx_data,
  output logic [1:0]                tx_control,
  output logic [tx_pkg::CNT_W-1:0]  data_cnt,
  output tx_pkg::frame_t            frame_type,
  output logic                      rd_req,
  output logic [tx_pkg::ADDR_W-1:0] sram_raddr
);

  logic                     start_read;
  logic [tx_pkg::ROW_W-1:0] row;
  logic                     read_done;
  logic                     rd_en;
  logic                     empty;
  tx_pkg::sram_word_t       fifo_dout;

  // frame and row control
  tx_sequencer u_sequencer (
    .sys_clk          (sys_clk),
    .reset            (reset),
    .timing_telemetry (timing_telemetry),
    .timing_lightdiag (timing_lightdiag),
    .timing_stardiag  (timing_stardiag),
    .read_done        (read_done),
    .start_read       (start_read),
    .row              (row),
    .frame_type       (frame_type),
    .transmit_done    (transmit_done)
  );

  // sram words for the current row
  line_fifo #(
    .payload_t (tx_pkg::sram_word_t)
  ) u_line_fifo (
    .sys_clk (sys_clk),
    .reset   (reset),
    .wr_en   (fifo_wr_en),
    .wdata   (fifo_wdata),
    .rd_en   (rd_en),
    .dout    (fifo_dout),
    .empty   (empty)
  );

  // sram request and link serializer
  frame_builder u_builder (
    .sys_clk    (sys_clk),
    .reset      (reset),
    .start_read (start_read),
    .row        (row),
    .frame_type (frame_type),
    .read_done  (read_done),
    .rd_req     (rd_req),
    .sram_raddr (sram_raddr),
    .rd_en      (rd_en),
    .empty      (empty),
    .fifo_data  (fifo_dout),
    .tx_data    (tx_data),
    .tx_control (tx_control),
    .data_cnt   (data_cnt)
  );

endmodule

//--- testbench/data_tx_props.sv
`timescale 1ns/1ps

module data_tx_props (
  input logic       sys_clk,
  input logic       reset,
  input logic       rd_req,
  input logic       transmit_done,
  input logic [1:0] tx_control
);

  int fail_count;

  initial
    fail_count = 0;

  // sram read request is a single-cycle pulse
  req_single_cycle: assert property (
    @(posedge sys_clk) disable iff (reset) rd_req |=> !rd_req
  )
  else
  begin
    $error("rd_req stayed high for more than one cycle");
    fail_count++;
  end

  // 10 is not a legal control pair on the link
  ctrl_legal: assert property (
    @(posedge sys_clk) disable iff (reset) tx_control != 2'b10
  )
  else
  begin
    $error("tx_control carried the illegal value 2'b10");
    fail_count++;
  end

  done_apart_from_req: assert property (
    @(posedge sys_clk) disable iff (reset) !(transmit_done && rd_req)
  )
  else
  begin
    $error("transmit_done pulsed together with rd_req");
    fail_count++;
  end

endmodule

bind data_tx data_tx_props props_i (
  .sys_clk       (sys_clk),
  .reset         (reset),
  .rd_req        (rd_req),
  .transmit_done (transmit_done),
  .tx_control    (tx_control)
);

//--- testbench/data_tx_checker.sv
`timescale 1ns/1ps

module data_tx_checker (
  input  logic                      sys_clk,
  input  logic                      reset,
  input  logic                      timing_telemetry,
  input  logic                      timing_lightdiag,
  input  logic                      timing_stardiag,
  input  logic                      fifo_wr_en,
  input  logic [31:0]               fifo_wdata,
  input  logic                      transmit_done,
  input  logic [15:0]               tx_data,
  input  logic [1:0]                tx_control,
  input  logic [tx_pkg::CNT_W-1:0]  data_cnt,
  input  logic [1:0]                frame_type,
  input  logic                      rd_req,
  input  logic [tx_pkg::ADDR_W-1:0] sram_raddr,
  output logic                      busy,
  output int                        error_count,
  output int                        frame_count,
  output int                        row_count,
  output int                        pending
);

  localparam int LINK_IDLE    = 0;
  localparam int LINK_SOF     = 1;
  localparam int LINK_HDR     = 2;
  localparam int LINK_PAYLOAD = 3;

  logic [31:0] words [$];
  logic [2:0]  strobes;
  logic [2:0]  strobe_q;
  logic [2:0]  rises;
  logic [1:0]  exp_frame;
  logic [10:0] exp_row;
  logic [10:0] cur_row;
  logic [31:0] cur_word;
  logic [15:0] exp_half;
  int          link_state;
  int          pay_idx;
  int          quiet;

  initial
  begin
    error_count = 0;
    frame_count = 0;
    row_count   = 0;
    pending     = 0;
    busy        = 1'b0;
    strobe_q    = 3'b000;
  end

  function automatic int rows_for(input logic [1:0] f);
    case (f)
      2'd1:    return tx_pkg::ROWS_TELEMETRY;
      2'd2:    return tx_pkg::ROWS_LIGHTDIAG;
      2'd3:    return tx_pkg::ROWS_STARDIAG;
      default: return 0;
    endcase
  endfunction

  // type base plus row times words per row
  function automatic logic [23:0] expected_addr(input logic [1:0] f, input logic [10:0] r);
    logic [23:0] base;
    case (f)
      2'd2:    base = tx_pkg::BASE_LIGHTDIAG;
      2'd3:    base = tx_pkg::BASE_STARDIAG;
      default: base = tx_pkg::BASE_TELEMETRY;
    endcase
    return base + r * tx_pkg::WORDS_PER_ROW;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got)
    begin
      error_count++;
      $display("ERROR %s expected 0x%0h got 0x%0h at %0t", name, exp, got, $time);
    end
  endtask

  task automatic report_fault(input string what);
    error_count++;
    $display("ERROR at %0t: %s", $time, what);
  endtask

  task automatic expect_idle();
    compare_value("tx_data", 32'(tx_pkg::IDLE_WORD), 32'(tx_data));
    compare_value("tx_control", 32'(2'b01), 32'(tx_control));
    compare_value("data_cnt", 32'd0, 32'(data_cnt));
  endtask

  // ----------------------------------------
  // link word check, one word per cycle
  // ----------------------------------------
  task automatic check_link_word();
    case (link_state)
      LINK_SOF:
      begin
        compare_value("tx_data", 32'(tx_pkg::SOF_WORD), 32'(tx_data));
        compare_value("tx_control", 32'(2'b11), 32'(tx_control));
        compare_value("data_cnt", 32'd0, 32'(data_cnt));
        link_state = LINK_HDR;
      end
      LINK_HDR:
      begin
        compare_value("tx_data", 32'({exp_frame, 3'b000, cur_row}), 32'(tx_data));
        compare_value("tx_control", 32'(2'b00), 32'(tx_control));
        compare_value("data_cnt", 32'd0, 32'(data_cnt));
        pay_idx    = 0;
        link_state = LINK_PAYLOAD;
      end
      LINK_PAYLOAD:
      begin
        // idle commas may fill a starved fifo
        if (tx_control == 2'b01)
          expect_idle();
        else
        begin
          compare_value("tx_control", 32'(2'b00), 32'(tx_control));
          if (pay_idx % 2 == 0)
          begin
            if (words.size() == 0)
            begin
              report_fault("payload word sent but no SRAM word was written for it");
              cur_word = '0;
            end
            else
              cur_word = words.pop_front();
            exp_half = cur_word[31:16];
          end
          else
            exp_half = cur_word[15:0];
          compare_value("tx_data", 32'(exp_half), 32'(tx_data));
          pay_idx++;
          compare_value("data_cnt", 32'(pay_idx), 32'(data_cnt));
          if (pay_idx == tx_pkg::WORDS_PER_ROW * 2)
          begin
            row_count++;
            link_state = LINK_IDLE;
          end
        end
      end
      default:
        expect_idle();
    endcase
  endtask

  always @(posedge sys_clk)
  begin
    strobes = {timing_stardiag, timing_lightdiag, timing_telemetry};
    if (reset)
    begin
      words.delete();
      busy       = 1'b0;
      exp_frame  = 2'd0;
      exp_row    = '0;
      cur_row    = '0;
      link_state = LINK_IDLE;
      pay_idx    = 0;
      quiet      = 0;
    end
    else
    begin
      if (fifo_wr_en)
        words.push_back(fifo_wdata);
      // edges count only while no frame runs, telemetry wins
      rises = strobes & ~strobe_q;
      if (!busy && rises != 3'b000)
      begin
        busy    = 1'b1;
        exp_row = '0;
        quiet   = 0;
        if (rises[0])
          exp_frame = 2'd1;
        else if (rises[1])
          exp_frame = 2'd2;
        else
          exp_frame = 2'd3;
      end
      quiet++;
      if (!busy && quiet > 4)
        compare_value("frame_type", 32'd0, 32'(frame_type));
      check_link_word();
      if (rd_req)
      begin
        if (!busy || exp_row == rows_for(exp_frame))
          report_fault("rd_req arrived with no row left to send");
        else
        begin
          if (link_state != LINK_IDLE)
            report_fault("rd_req arrived before the previous row was complete");
          compare_value("sram_raddr", 32'(expected_addr(exp_frame, exp_row)), 32'(sram_raddr));
          compare_value("frame_type", 32'(exp_frame), 32'(frame_type));
          cur_row    = exp_row;
          exp_row    = exp_row + 11'd1;
          link_state = LINK_SOF;
        end
      end
      if (transmit_done)
      begin
        if (!busy)
          report_fault("transmit_done pulsed outside a frame");
        else
        begin
          if (exp_row != rows_for(exp_frame) || link_state != LINK_IDLE)
            report_fault("transmit_done pulsed before the last row was sent");
          busy  = 1'b0;
          quiet = 0;
          frame_count++;
        end
      end
    end
    strobe_q = strobes;
    pending  = words.size();
  end

endmodule

//--- testbench/data_tx_tb.sv
`timescale 1ns/1ps

module data_tx_tb;

  localparam int MAX_CASES   = 32;
  localparam int HOLD_CYCLES = 4;

  logic                      sys_clk;
  logic                      reset;
  logic                      timing_telemetry;
  logic                      timing_lightdiag;
  logic                      timing_stardiag;
  logic                      fifo_wr_en;
  tx_pkg::sram_word_t        fifo_wdata;
  logic                      transmit_done;
  tx_pkg::link_word_t        tx_data;
  logic [1:0]                tx_control;
  logic [tx_pkg::CNT_W-1:0]  data_cnt;
  tx_pkg::frame_t            frame_type;
  logic                      rd_req;
  logic [tx_pkg::ADDR_W-1:0] sram_raddr;

  logic busy;
  int   error_count;
  int   frame_count;
  int   row_count;
  int   pending;

  logic [7:0]  case_trig [MAX_CASES];
  int          case_lat [MAX_CASES];
  int          case_gap [MAX_CASES];
  int          num_cases;
  logic        cases_loaded;
  int          latency;
  logic [31:0] rng;
  int          idx;

  data_tx dut_i (
    .sys_clk          (sys_clk),
    .reset            (reset),
    .timing_telemetry (timing_telemetry),
    .timing_lightdiag (timing_lightdiag),
    .timing_stardiag  (timing_stardiag),
    .fifo_wr_en       (fifo_wr_en),
    .fifo_wdata       (fifo_wdata),
    .transmit_done    (transmit_done),
    .tx_data          (tx_data),
    .tx_control       (tx_control),
    .data_cnt         (data_cnt),
    .frame_type       (frame_type),
    .rd_req           (rd_req),
    .sram_raddr       (sram_raddr)
  );

  data_tx_checker chk_i (
    .sys_clk          (sys_clk),
    .reset            (reset),
    .timing_telemetry (timing_telemetry),
    .timing_lightdiag (timing_lightdiag),
    .timing_stardiag  (timing_stardiag),
    .fifo_wr_en       (fifo_wr_en),
    .fifo_wdata       (fifo_wdata),
    .transmit_done    (transmit_done),
    .tx_data          (tx_data),
    .tx_control       (tx_control),
    .data_cnt         (data_cnt),
    .frame_type       (frame_type),
    .rd_req           (rd_req),
    .sram_raddr       (sram_raddr),
    .busy             (busy),
    .error_count      (error_count),
    .frame_count      (frame_count),
    .row_count        (row_count),
    .pending          (pending)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  initial
  begin
    sys_clk = 1'b0;
    forever
      #5 sys_clk = ~sys_clk;
  end

  // ----------------------------------------
  // case file
  // ----------------------------------------
  task automatic load_cases();
    int         fd;
    string      line;
    logic [7:0] trig;
    int         lat;
    int         gap;
    num_cases = 0;
    fd = $fopen("testbench/data_tx_cases.txt", "r");
    if (fd != 0)
    begin
      while ($fgets(line, fd) != 0)
      begin
        if (line.len() > 0 && line[0] != "#" && num_cases < MAX_CASES)
        begin
          if ($sscanf(line, "%c %d %d", trig, lat, gap) == 3)
          begin
            case_trig[num_cases] = trig;
            case_lat[num_cases]  = lat;
            case_gap[num_cases]  = gap;
            num_cases++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // strobe held a few cycles, then the gap
  task automatic run_case(input logic [7:0] trig, input int gap);
    case (trig)
      "t":     timing_telemetry = 1'b1;
      "l":     timing_lightdiag = 1'b1;
      "s":     timing_stardiag  = 1'b1;
      default:
      begin
        timing_telemetry = 1'b1;
        timing_lightdiag = 1'b1;
        timing_stardiag  = 1'b1;
      end
    endcase
    repeat (HOLD_CYCLES) @(negedge sys_clk);
    timing_telemetry = 1'b0;
    timing_lightdiag = 1'b0;
    timing_stardiag  = 1'b0;
    repeat (gap) @(negedge sys_clk);
  endtask

  // ----------------------------------------
  // sram controller model
  // ----------------------------------------
  task automatic write_row();
    int i;
    repeat (latency) @(negedge sys_clk);
    for (i = 0; i < tx_pkg::WORDS_PER_ROW; i++)
    begin
      rng        = lcg_next(rng);
      fifo_wr_en = 1'b1;
      fifo_wdata = rng;
      @(negedge sys_clk);
      fifo_wr_en = 1'b0;
      // one word per two cycles, the rate the link drains it
      @(negedge sys_clk);
      rng        = lcg_next(rng);
      // a hole now and then starves the fifo
      if (rng[31:30] == 2'b00)
        @(negedge sys_clk);
    end
  endtask

  initial
  begin : sram_model
    forever
    begin
      @(negedge sys_clk);
      if (!reset && rd_req)
        write_row();
    end
  end

  initial
  begin : watchdog
    wait (cases_loaded);
    repeat (400 * num_cases + 100) @(posedge sys_clk);
    $display("timeout: the frames did not complete within %0d cycles", 400 * num_cases + 100);
    $display("Verification failed");
    $finish;
  end

  initial
  begin : main
    reset            = 1'b1;
    timing_telemetry = 1'b0;
    timing_lightdiag = 1'b0;
    timing_stardiag  = 1'b0;
    fifo_wr_en       = 1'b0;
    fifo_wdata       = '0;
    latency          = 0;
    rng              = 32'hfc4f;
    cases_loaded     = 1'b0;
    load_cases();
    cases_loaded = 1'b1;
    repeat (16) @(negedge sys_clk);
    reset = 1'b0;
    // quiet link before the first trigger
    repeat (20) @(negedge sys_clk);
    for (idx = 0; idx < num_cases; idx++)
    begin
      latency = case_lat[idx];
      run_case(case_trig[idx], case_gap[idx]);
    end
    while (busy)
      @(negedge sys_clk);
    repeat (10) @(negedge sys_clk);
    if (num_cases == 0)
      $display("no test cases could be read from testbench/data_tx_cases.txt");
    $display("cases %0d frames %0d rows %0d errors %0d assertion failures %0d unsent words %0d",
             num_cases, frame_count, row_count, error_count, dut_i.props_i.fail_count, pending);
    if (num_cases > 0 && error_count == 0 && dut_i.props_i.fail_count == 0 && pending == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

//--- testbench/data_tx_cases.txt
# trigger (t telemetry, l light diag, s star diag, a all three), sram latency, gap
# gap is counted in cycles from the strobe falling to the next trigger
t 2 200
l 4 200
s 0 200
a 3 200
t 1 26
l 6 200
l 12 26
s 2 200
s 9 200
a 0 200
t 15 200
l 1 200

//--- tb.f
hw/tx_pkg.sv
hw/tx_sequencer.sv
hw/line_fifo.sv
hw/frame_builder.sv
hw/data_tx.sv
testbench/data_tx_props.sv
testbench/data_tx_checker.sv
testbench/data_tx_tb.sv

//--- Bender.yml
package:
  name: data_tx

sources:
  - hw/tx_pkg.sv
  - hw/tx_sequencer.sv
  - hw/line_fifo.sv
  - hw/frame_builder.sv
  - hw/data_tx.sv
  - target: test
    files:
      - testbench/data_tx_props.sv
      - testbench/data_tx_checker.sv
      - testbench/data_tx_tb.sv
